//--- hdl/isa_pkg.sv
package isa_pkg;

	localparam int WORD_SIZE = 16;

	typedef logic [WORD_SIZE-1:0] word_t;
	typedef logic [1:0] reg_idx_t;
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;
	typedef logic [2:0] alu_op_t;

	// Opcodes in bits 15:12
	localparam opcode_t OP_BNE   = 4'd0;
	localparam opcode_t OP_BEQ   = 4'd1;
	localparam opcode_t OP_BGZ   = 4'd2;
	localparam opcode_t OP_BLZ   = 4'd3;
	localparam opcode_t OP_ADI   = 4'd4;
	localparam opcode_t OP_ORI   = 4'd5;
	localparam opcode_t OP_LHI   = 4'd6;
	localparam opcode_t OP_LWD   = 4'd7;
	localparam opcode_t OP_SWD   = 4'd8;
	localparam opcode_t OP_JMP   = 4'd9;
	localparam opcode_t OP_JAL   = 4'd10;
	localparam opcode_t OP_RTYPE = 4'd15;

	// Function codes in bits 5:0 under OP_RTYPE
	localparam func_t FUNC_ADD = 6'd0;
	localparam func_t FUNC_SUB = 6'd1;
	localparam func_t FUNC_AND = 6'd2;
	localparam func_t FUNC_ORR = 6'd3;
	localparam func_t FUNC_NOT = 6'd4;
	localparam func_t FUNC_TCP = 6'd5;
	localparam func_t FUNC_SHL = 6'd6;
	localparam func_t FUNC_SHR = 6'd7;
	localparam func_t FUNC_JPR = 6'd25;
	localparam func_t FUNC_JRL = 6'd26;
	localparam func_t FUNC_WWD = 6'd28;
	localparam func_t FUNC_HLT = 6'd29;

	// Same numbering as the low bits of the R-type function codes
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_ORR = 3'd3;
	localparam alu_op_t ALU_NOT = 3'd4;
	localparam alu_op_t ALU_TCP = 3'd5;
	localparam alu_op_t ALU_SHL = 3'd6;
	localparam alu_op_t ALU_SHR = 3'd7;

endpackage

//--- hdl/pipe_pkg.sv
package pipe_pkg;

	// Operand B of the ALU
	typedef enum logic [1:0] {
		SRC_REG = 2'd0,
		SRC_IMM = 2'd1,
		// Immediate moved to the upper byte
		SRC_LHI = 2'd2
	} alu_src_t;

	// Source of an execute operand
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_WB  = 2'd1,
		FWD_MEM = 2'd2
	} fwd_sel_t;

	// Destination register field
	typedef enum logic [1:0] {
		DEST_RD = 2'd0,
		DEST_RT = 2'd1,
		// Link register of JAL and JRL
		DEST_R2 = 2'd2
	} dest_sel_t;

endpackage

//--- hdl/control_decoder.sv
`timescale 1ns/1ns

module control_decoder (
	input  isa_pkg::word_t      instruction,
	input  logic                flush,
	output pipe_pkg::alu_src_t  alu_src,
	output isa_pkg::alu_op_t    alu_op,
	output pipe_pkg::dest_sel_t dest_sel,
	output logic                mem_read,
	output logic                mem_write,
	output logic                reg_write,
	output logic                mem_to_reg,
	output logic                pc_to_reg,
	output logic                is_wwd,
	output logic                is_halt,
	output logic                jtype_jump,
	output logic                rtype_jump,
	output logic                branch
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t opcode;
	func_t   func;

	assign opcode = instruction[15:12];
	assign func   = instruction[5:0];

	always_comb begin
		alu_src    = SRC_REG;
		alu_op     = ALU_ADD;
		dest_sel   = DEST_RD;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		reg_write  = 1'b0;
		mem_to_reg = 1'b0;
		pc_to_reg  = 1'b0;
		is_wwd     = 1'b0;
		is_halt    = 1'b0;
		jtype_jump = 1'b0;
		rtype_jump = 1'b0;
		branch     = 1'b0;

		case (opcode)
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
				branch = 1'b1;
			end
			OP_ADI: begin
				alu_src   = SRC_IMM;
				dest_sel  = DEST_RT;
				reg_write = 1'b1;
			end
			// ORI takes the sign-extended immediate like ADI
			OP_ORI: begin
				alu_src   = SRC_IMM;
				alu_op    = ALU_ORR;
				dest_sel  = DEST_RT;
				reg_write = 1'b1;
			end
			OP_LHI: begin
				alu_src   = SRC_LHI;
				dest_sel  = DEST_RT;
				reg_write = 1'b1;
			end
			OP_LWD: begin
				alu_src    = SRC_IMM;
				dest_sel   = DEST_RT;
				reg_write  = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
			end
			OP_SWD: begin
				alu_src   = SRC_IMM;
				mem_write = 1'b1;
			end
			OP_JMP: begin
				jtype_jump = 1'b1;
			end
			OP_JAL: begin
				jtype_jump = 1'b1;
				reg_write  = 1'b1;
				pc_to_reg  = 1'b1;
				dest_sel   = DEST_R2;
			end
			OP_RTYPE: begin
				case (func)
					FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR,
					FUNC_NOT, FUNC_TCP, FUNC_SHL, FUNC_SHR: begin
						alu_op    = alu_op_t'(func[2:0]);
						reg_write = 1'b1;
					end
					FUNC_WWD: is_wwd = 1'b1;
					FUNC_JPR: rtype_jump = 1'b1;
					FUNC_JRL: begin
						rtype_jump = 1'b1;
						reg_write  = 1'b1;
						pc_to_reg  = 1'b1;
						dest_sel   = DEST_R2;
					end
					FUNC_HLT: is_halt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase

		// Bubble in decode
		if (flush) begin
			mem_read   = 1'b0;
			mem_write  = 1'b0;
			reg_write  = 1'b0;
			is_wwd     = 1'b0;
			is_halt    = 1'b0;
			jtype_jump = 1'b0;
			rtype_jump = 1'b0;
			branch     = 1'b0;
		end
	end

endmodule

//--- hdl/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit (
	input  isa_pkg::reg_idx_t  ex_rs,
	input  isa_pkg::reg_idx_t  ex_rt,
	input  isa_pkg::reg_idx_t  mem_dest,
	input  isa_pkg::reg_idx_t  wb_dest,
	input  logic               mem_reg_write,
	input  logic               wb_reg_write,
	output pipe_pkg::fwd_sel_t forward_a,
	output pipe_pkg::fwd_sel_t forward_b
);
	import pipe_pkg::*;

	// The memory stage holds the younger result
	always_comb begin
		if (mem_reg_write && mem_dest == ex_rs)
			forward_a = FWD_MEM;
		else if (wb_reg_write && wb_dest == ex_rs)
			forward_a = FWD_WB;
		else
			forward_a = FWD_REG;
	end

	always_comb begin
		if (mem_reg_write && mem_dest == ex_rt)
			forward_b = FWD_MEM;
		else if (wb_reg_write && wb_dest == ex_rt)
			forward_b = FWD_WB;
		else
			forward_b = FWD_REG;
	end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ns

module register_file (
	input  logic              Clk,
	input  isa_pkg::reg_idx_t read1,
	input  isa_pkg::reg_idx_t read2,
	input  isa_pkg::reg_idx_t write_reg,
	input  isa_pkg::word_t    write_data,
	input  logic              reg_write,
	output isa_pkg::word_t    read_out1,
	output isa_pkg::word_t    read_out2
);
	import isa_pkg::*;

	word_t regs [4];

	always_ff @(posedge Clk) begin
		if (reg_write)
			regs[write_reg] <= write_data;
	end

	// Writeback result reaches decode in the same cycle
	assign read_out1 = (reg_write && write_reg == read1) ? write_data : regs[read1];
	assign read_out2 = (reg_write && write_reg == read2) ? write_data : regs[read2];

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu (
	input  isa_pkg::word_t   a,
	input  isa_pkg::word_t   b,
	input  isa_pkg::alu_op_t alu_op,
	output isa_pkg::word_t   result
);
	import isa_pkg::*;

	always_comb begin
		case (alu_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_ORR: result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + 1'b1;
			ALU_SHL: result = {a[WORD_SIZE-2:0], 1'b0};
			// Arithmetic, sign bit kept
			ALU_SHR: result = {a[WORD_SIZE-1], a[WORD_SIZE-1:1]};
			default: result = '0;
		endcase
	end

endmodule

//--- hdl/cpu.sv
`timescale 1ns/1ns

module cpu (
	input  logic           Clk,
	input  logic           reset,
	output logic           inst_read,
	output isa_pkg::word_t inst_addr,
	input  isa_pkg::word_t inst_data,
	output logic           data_read,
	output logic           data_write,
	output isa_pkg::word_t data_addr,
	output isa_pkg::word_t data_wdata,
	input  isa_pkg::word_t data_rdata,
	output isa_pkg::word_t output_port,
	output logic           output_valid,
	output isa_pkg::word_t num_inst,
	output logic           is_halted
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t pc;
	logic fetch_en, halted;
	word_t inst_count;

	word_t if_id_instruction, if_id_pc;
	logic if_id_valid;

	opcode_t id_opcode;
	func_t id_func;
	reg_idx_t id_rs, id_rt;
	word_t read_out1, read_out2, id_imm;
	logic uses_rs, uses_rt, stall, decode_live, dec_flush;
	alu_src_t dec_alu_src;
	alu_op_t dec_alu_op;
	dest_sel_t dec_dest_sel;
	logic dec_mem_read, dec_mem_write, dec_reg_write, dec_mem_to_reg, dec_pc_to_reg;
	logic dec_is_wwd, dec_is_halt, dec_jtype_jump, dec_rtype_jump, dec_branch;

	logic id_ex_valid;
	word_t id_ex_pc, id_ex_read_out1, id_ex_read_out2, id_ex_imm, id_ex_jump_target;
	opcode_t id_ex_opcode;
	reg_idx_t id_ex_rs, id_ex_rt, id_ex_rd;
	alu_src_t id_ex_alu_src;
	alu_op_t id_ex_alu_op;
	dest_sel_t id_ex_dest_sel;
	logic id_ex_mem_read, id_ex_mem_write, id_ex_reg_write, id_ex_mem_to_reg, id_ex_pc_to_reg;
	logic id_ex_is_wwd, id_ex_is_halt, id_ex_jtype_jump, id_ex_rtype_jump, id_ex_branch;

	fwd_sel_t forward_a, forward_b;
	word_t reg_a, reg_b, alu_a, alu_b, alu_result, ex_result, next_target;
	reg_idx_t ex_dest;
	logic bcond, redirect, ex_halt;

	word_t ex_mem_result, ex_mem_store_data;
	reg_idx_t ex_mem_dest;
	logic ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_to_reg;

	word_t mem_wb_result, mem_wb_read_data, wb_data;
	reg_idx_t mem_wb_dest;
	logic mem_wb_reg_write, mem_wb_mem_to_reg;

	assign ex_halt     = id_ex_is_halt;
	assign is_halted   = halted | ex_halt;
	assign inst_read   = fetch_en & ~is_halted;
	assign inst_addr   = pc;
	assign num_inst    = inst_count;
	assign output_valid = id_ex_is_wwd;
	assign output_port = id_ex_is_wwd ? reg_a : '0;

	always_ff @(posedge Clk) begin
		if (reset) begin
			pc <= '0;
			fetch_en <= 1'b0;
			halted <= 1'b0;
			inst_count <= '0;
		end else begin
			fetch_en <= 1'b1;
			if (redirect)
				pc <= next_target;
			else if (inst_read && !stall)
				pc <= pc + 1'b1;
			if (ex_halt)
				halted <= 1'b1;
			if (id_ex_valid)
				inst_count <= inst_count + 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		if (reset)
			if_id_valid <= 1'b0;
		else if (redirect || is_halted)
			if_id_valid <= 1'b0;
		else if (!stall)
			if_id_valid <= inst_read;
	end

	always_ff @(posedge Clk) begin
		if (!stall) begin
			if_id_instruction <= inst_data;
			if_id_pc <= pc + 1'b1;
		end
	end

	assign id_opcode = if_id_instruction[15:12];
	assign id_func   = if_id_instruction[5:0];
	assign id_rs     = if_id_instruction[11:10];
	assign id_rt     = if_id_instruction[9:8];
	assign id_imm    = {{8{if_id_instruction[7]}}, if_id_instruction[7:0]};

	// Load-use hazard against the load now in execute
	assign uses_rs = !(id_opcode inside {OP_JMP, OP_JAL, OP_LHI});
	assign uses_rt = (id_opcode inside {OP_BNE, OP_BEQ, OP_SWD}) ||
		(id_opcode == OP_RTYPE && id_func <= FUNC_SHR);
	assign stall = if_id_valid && id_ex_mem_read &&
		((uses_rs && id_rs == ex_dest) || (uses_rt && id_rt == ex_dest));
	assign decode_live = if_id_valid && !stall && !redirect && !is_halted;
	assign dec_flush = ~decode_live;

	control_decoder u_control_decoder (
		.instruction(if_id_instruction),
		.flush(dec_flush),
		.alu_src(dec_alu_src),
		.alu_op(dec_alu_op),
		.dest_sel(dec_dest_sel),
		.mem_read(dec_mem_read),
		.mem_write(dec_mem_write),
		.reg_write(dec_reg_write),
		.mem_to_reg(dec_mem_to_reg),
		.pc_to_reg(dec_pc_to_reg),
		.is_wwd(dec_is_wwd),
		.is_halt(dec_is_halt),
		.jtype_jump(dec_jtype_jump),
		.rtype_jump(dec_rtype_jump),
		.branch(dec_branch)
	);

	register_file u_register_file (
		.Clk(Clk),
		.read1(id_rs),
		.read2(id_rt),
		.write_reg(mem_wb_dest),
		.write_data(wb_data),
		.reg_write(mem_wb_reg_write),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	always_ff @(posedge Clk) begin
		if (reset) begin
			id_ex_valid <= 1'b0;
			id_ex_alu_src <= SRC_REG;
			id_ex_alu_op <= ALU_ADD;
			id_ex_dest_sel <= DEST_RD;
			id_ex_mem_read <= 1'b0;
			id_ex_mem_write <= 1'b0;
			id_ex_reg_write <= 1'b0;
			id_ex_mem_to_reg <= 1'b0;
			id_ex_pc_to_reg <= 1'b0;
			id_ex_is_wwd <= 1'b0;
			id_ex_is_halt <= 1'b0;
			id_ex_jtype_jump <= 1'b0;
			id_ex_rtype_jump <= 1'b0;
			id_ex_branch <= 1'b0;
		end else begin
			id_ex_valid <= decode_live;
			id_ex_alu_src <= dec_alu_src;
			id_ex_alu_op <= dec_alu_op;
			id_ex_dest_sel <= dec_dest_sel;
			id_ex_mem_read <= dec_mem_read;
			id_ex_mem_write <= dec_mem_write;
			id_ex_reg_write <= dec_reg_write;
			id_ex_mem_to_reg <= dec_mem_to_reg;
			id_ex_pc_to_reg <= dec_pc_to_reg;
			id_ex_is_wwd <= dec_is_wwd;
			id_ex_is_halt <= dec_is_halt;
			id_ex_jtype_jump <= dec_jtype_jump;
			id_ex_rtype_jump <= dec_rtype_jump;
			id_ex_branch <= dec_branch;
		end
	end

	always_ff @(posedge Clk) begin
		id_ex_pc <= if_id_pc;
		id_ex_opcode <= id_opcode;
		id_ex_rs <= id_rs;
		id_ex_rt <= id_rt;
		id_ex_rd <= if_id_instruction[7:6];
		id_ex_read_out1 <= read_out1;
		id_ex_read_out2 <= read_out2;
		id_ex_imm <= id_imm;
		id_ex_jump_target <= {if_id_pc[15:12], if_id_instruction[11:0]};
	end

	forwarding_unit u_forwarding_unit (
		.ex_rs(id_ex_rs),
		.ex_rt(id_ex_rt),
		.mem_dest(ex_mem_dest),
		.wb_dest(mem_wb_dest),
		.mem_reg_write(ex_mem_reg_write),
		.wb_reg_write(mem_wb_reg_write),
		.forward_a(forward_a),
		.forward_b(forward_b)
	);

	always_comb begin
		case (forward_a)
			FWD_MEM: reg_a = ex_mem_result;
			FWD_WB:  reg_a = wb_data;
			default: reg_a = id_ex_read_out1;
		endcase
		case (forward_b)
			FWD_MEM: reg_b = ex_mem_result;
			FWD_WB:  reg_b = wb_data;
			default: reg_b = id_ex_read_out2;
		endcase
	end

	// LHI adds its shifted immediate to zero
	assign alu_a = (id_ex_alu_src == SRC_LHI) ? '0 : reg_a;

	always_comb begin
		case (id_ex_alu_src)
			SRC_IMM: alu_b = id_ex_imm;
			SRC_LHI: alu_b = {id_ex_imm[7:0], 8'h00};
			default: alu_b = reg_b;
		endcase
	end

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.alu_op(id_ex_alu_op),
		.result(alu_result)
	);

	// Return address is chosen here so the memory stage forwards one value
	assign ex_result = id_ex_pc_to_reg ? id_ex_pc : alu_result;

	always_comb begin
		case (id_ex_dest_sel)
			DEST_RT: ex_dest = id_ex_rt;
			DEST_R2: ex_dest = 2'd2;
			default: ex_dest = id_ex_rd;
		endcase
	end

	always_comb begin
		case (id_ex_opcode)
			OP_BNE:  bcond = reg_a != reg_b;
			OP_BEQ:  bcond = reg_a == reg_b;
			OP_BGZ:  bcond = $signed(reg_a) > 0;
			OP_BLZ:  bcond = reg_a[WORD_SIZE-1];
			default: bcond = 1'b0;
		endcase
	end

	assign redirect = id_ex_jtype_jump | id_ex_rtype_jump | (id_ex_branch & bcond);

	always_comb begin
		if (id_ex_rtype_jump)
			next_target = reg_a;
		else if (id_ex_jtype_jump)
			next_target = id_ex_jump_target;
		else
			next_target = id_ex_pc + id_ex_imm;
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			ex_mem_reg_write <= 1'b0;
			ex_mem_mem_read <= 1'b0;
			ex_mem_mem_write <= 1'b0;
			ex_mem_mem_to_reg <= 1'b0;
			mem_wb_reg_write <= 1'b0;
			mem_wb_mem_to_reg <= 1'b0;
		end else begin
			ex_mem_reg_write <= id_ex_reg_write;
			ex_mem_mem_read <= id_ex_mem_read;
			ex_mem_mem_write <= id_ex_mem_write;
			ex_mem_mem_to_reg <= id_ex_mem_to_reg;
			mem_wb_reg_write <= ex_mem_reg_write;
			mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
		end
	end

	always_ff @(posedge Clk) begin
		ex_mem_result <= ex_result;
		ex_mem_store_data <= reg_b;
		ex_mem_dest <= ex_dest;
		mem_wb_result <= ex_mem_result;
		mem_wb_read_data <= data_rdata;
		mem_wb_dest <= ex_mem_dest;
	end

	assign data_read  = ex_mem_mem_read;
	assign data_write = ex_mem_mem_write;
	assign data_addr  = ex_mem_result;
	assign data_wdata = ex_mem_store_data;

	assign wb_data = mem_wb_mem_to_reg ? mem_wb_read_data : mem_wb_result;

endmodule

//--- hdl/dual_port_memory.sv
`timescale 1ns/1ns

module dual_port_memory #(
	parameter int MEM_DEPTH = 1024
) (
	input  logic           Clk,
	input  logic           inst_read,
	input  isa_pkg::word_t inst_addr,
	output isa_pkg::word_t inst_data,
	input  logic           data_read,
	input  logic           data_write,
	input  isa_pkg::word_t data_addr,
	input  isa_pkg::word_t data_wdata,
	output isa_pkg::word_t data_rdata,
	input  logic           load_en,
	input  isa_pkg::word_t load_addr,
	input  isa_pkg::word_t load_data
);
	import isa_pkg::*;

	localparam int ADDR_BITS = $clog2(MEM_DEPTH);

	word_t mem [MEM_DEPTH];

	// Backdoor load wins over a data write
	always_ff @(posedge Clk) begin
		if (load_en)
			mem[load_addr[ADDR_BITS-1:0]] <= load_data;
		else if (data_write)
			mem[data_addr[ADDR_BITS-1:0]] <= data_wdata;
	end

	assign inst_data  = inst_read ? mem[inst_addr[ADDR_BITS-1:0]] : '0;
	assign data_rdata = data_read ? mem[data_addr[ADDR_BITS-1:0]] : '0;

endmodule

//--- hdl/tsc_system.sv
`timescale 1ns/1ns

module tsc_system #(
	parameter int MEM_DEPTH = 1024
) (
	input  logic           Clk,
	input  logic           reset,
	input  logic           load_en,
	input  isa_pkg::word_t load_addr,
	input  isa_pkg::word_t load_data,
	output isa_pkg::word_t output_port,
	output logic           output_valid,
	output isa_pkg::word_t num_inst,
	output logic           is_halted
);
	import isa_pkg::*;

	logic inst_read, data_read, data_write;
	word_t inst_addr, inst_data, data_addr, data_wdata, data_rdata;

	cpu u_cpu (
		.Clk(Clk),
		.reset(reset),
		.inst_read(inst_read),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.output_port(output_port),
		.output_valid(output_valid),
		.num_inst(num_inst),
		.is_halted(is_halted)
	);

	dual_port_memory #(
		.MEM_DEPTH(MEM_DEPTH)
	) u_memory (
		.Clk(Clk),
		.inst_read(inst_read),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

endmodule

//--- tb/cpu_assertions.sv
`timescale 1ns/1ns

module cpu_assertions (
	input logic Clk,
	input logic reset,
	input logic data_read,
	input logic data_write,
	input logic output_valid,
	input logic is_halted
);
	int error_count = 0;

	// One data access per cycle
	data_port_exclusive: assert property (@(posedge Clk) disable iff (reset)
		!(data_read && data_write))
	else begin
		$error("data_read and data_write are high in the same cycle");
		error_count++;
	end

	no_output_when_halted: assert property (@(posedge Clk) disable iff (reset)
		output_valid |-> !is_halted)
	else begin
		$error("output_valid is high while is_halted is high");
		error_count++;
	end

	// Only reset clears the halt
	halt_is_sticky: assert property (@(posedge Clk) disable iff (reset)
		is_halted |=> is_halted)
	else begin
		$error("is_halted fell without a reset");
		error_count++;
	end

endmodule

bind cpu cpu_assertions u_cpu_assertions (
	.Clk(Clk),
	.reset(reset),
	.data_read(data_read),
	.data_write(data_write),
	.output_valid(output_valid),
	.is_halted(is_halted)
);

//--- tb/tsc_system_tb.sv
`timescale 1ns/1ns

module tsc_system_tb;
	import isa_pkg::*;

	localparam int CLK_PERIOD = 20;
	// Cycle budgets of the alu, forwarding, load/store, branch and jump tests
	localparam int WATCHDOG_CYCLES = 120 + 80 + 80 + 120 + 80;

	logic Clk;
	logic reset;
	logic load_en;
	word_t load_addr;
	word_t load_data;
	word_t output_port;
	logic output_valid;
	word_t num_inst;
	logic is_halted;

	word_t program_words [$];
	word_t expected [$];
	word_t observed [$];
	logic [31:0] lfsr_state;

	tsc_system #(
		.MEM_DEPTH(1024)
	) uut (
		.Clk(Clk),
		.reset(reset),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.output_port(output_port),
		.output_valid(output_valid),
		.num_inst(num_inst),
		.is_halted(is_halted)
	);

	always #(CLK_PERIOD / 2) Clk = ~Clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_word(input int nbits, output word_t value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[WORD_SIZE-2:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t rtype_inst(input reg_idx_t rs, input reg_idx_t rt,
		input reg_idx_t rd, input func_t func);
		return {OP_RTYPE, rs, rt, rd, func};
	endfunction

	function automatic word_t itype_inst(input opcode_t op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jtype_inst(input opcode_t op, input logic [11:0] target);
		return {op, target};
	endfunction

	function automatic word_t sign_extend(input logic [7:0] imm);
		return {{8{imm[7]}}, imm};
	endfunction

	function automatic word_t expected_alu(input func_t func, input word_t a, input word_t b);
		case (func)
			FUNC_ADD: return a + b;
			FUNC_SUB: return a - b;
			FUNC_AND: return a & b;
			FUNC_ORR: return a | b;
			FUNC_NOT: return ~a;
			FUNC_TCP: return 16'd0 - a;
			FUNC_SHL: return a << 1;
			FUNC_SHR: return word_t'($signed(a) >>> 1);
			default: return 'x;
		endcase
	endfunction

	function automatic logic branch_taken(input opcode_t op, input word_t a, input word_t b);
		case (op)
			OP_BNE: return a != b;
			OP_BEQ: return a == b;
			OP_BGZ: return $signed(a) > 16'sd0;
			OP_BLZ: return $signed(a) < 16'sd0;
			default: return 1'b0;
		endcase
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			report_failure($sformatf("Mismatch %s expected %h got %h", name, exp, act));
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("Mismatch %s expected %h got %h", name, exp, act));
	endtask

	task automatic wait_drive_slot();
		@(posedge Clk);
		#2;
	endtask

	task automatic emit(input word_t inst);
		program_words.push_back(inst);
	endtask

	task automatic put_const(input reg_idx_t r, input word_t value);
		logic [7:0] upper;
		// Upper byte absorbs the borrow of the sign-extended low byte
		upper = value[15:8] + value[7];
		emit(itype_inst(OP_LHI, 2'd0, r, upper));
		emit(itype_inst(OP_ADI, r, r, value[7:0]));
	endtask

	task automatic run_program(input string test_name, input int executed);
		logic done;
		$display("Running %s", test_name);
		// Fetched behind HLT and never executed
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_WWD));
		wait_drive_slot();
		reset = 1'b1;
		load_en = 1'b0;
		repeat (4)
			wait_drive_slot();
		for (int i = 0; i < program_words.size(); i++) begin
			load_en = 1'b1;
			load_addr = word_t'(i);
			load_data = program_words[i];
			wait_drive_slot();
		end
		load_en = 1'b0;
		reset = 1'b0;

		observed.delete();
		done = 1'b0;
		while (!done) begin
			@(negedge Clk);
			if (output_valid)
				observed.push_back(output_port);
			done = is_halted;
		end
		repeat (6) begin
			@(negedge Clk);
			compare_flag("is_halted", 1'b1, is_halted);
			compare_flag("output_valid", 1'b0, output_valid);
		end
		compare_word("num_inst", word_t'(executed), num_inst);

		if (observed.size() != expected.size())
			report_failure($sformatf("%s produced %0d outputs where %0d were expected",
				test_name, observed.size(), expected.size()));
		foreach (expected[i])
			compare_word($sformatf("output_port[%0d]", i), expected[i], observed[i]);
		program_words.delete();
		expected.delete();
	endtask

	task automatic alu_ops_test();
		func_t ops [8] = '{FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR,
			FUNC_NOT, FUNC_TCP, FUNC_SHL, FUNC_SHR};
		word_t a, b, imm_adi, imm_ori, imm_lhi;
		random_word(16, a);
		random_word(16, b);
		random_word(8, imm_adi);
		random_word(8, imm_ori);
		random_word(8, imm_lhi);
		put_const(2'd0, a);
		put_const(2'd1, b);
		foreach (ops[i]) begin
			emit(rtype_inst(2'd0, 2'd1, 2'd2, ops[i]));
			emit(rtype_inst(2'd2, 2'd0, 2'd0, FUNC_WWD));
			expected.push_back(expected_alu(ops[i], a, b));
		end
		emit(itype_inst(OP_ADI, 2'd1, 2'd3, imm_adi[7:0]));
		emit(rtype_inst(2'd3, 2'd0, 2'd0, FUNC_WWD));
		expected.push_back(b + sign_extend(imm_adi[7:0]));
		emit(itype_inst(OP_ORI, 2'd0, 2'd2, imm_ori[7:0]));
		emit(rtype_inst(2'd2, 2'd0, 2'd0, FUNC_WWD));
		expected.push_back(a | sign_extend(imm_ori[7:0]));
		emit(itype_inst(OP_LHI, 2'd0, 2'd3, imm_lhi[7:0]));
		emit(rtype_inst(2'd3, 2'd0, 2'd0, FUNC_WWD));
		expected.push_back({imm_lhi[7:0], 8'h00});
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_HLT));
		run_program("alu_ops_test", program_words.size());
	endtask

	task automatic forwarding_test();
		word_t c, imm, v0, v1, v2, v3;
		random_word(16, c);
		random_word(8, imm);
		put_const(2'd0, c);
		// Each result feeds the next one back to back
		emit(rtype_inst(2'd0, 2'd0, 2'd1, FUNC_ADD));
		v1 = c + c;
		emit(rtype_inst(2'd1, 2'd0, 2'd2, FUNC_SUB));
		v2 = v1 - c;
		emit(rtype_inst(2'd2, 2'd1, 2'd3, FUNC_AND));
		v3 = v2 & v1;
		emit(rtype_inst(2'd3, 2'd2, 2'd0, FUNC_ORR));
		v0 = v3 | v2;
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_WWD));
		emit(rtype_inst(2'd3, 2'd0, 2'd0, FUNC_WWD));
		emit(rtype_inst(2'd1, 2'd0, 2'd0, FUNC_WWD));
		emit(rtype_inst(2'd2, 2'd0, 2'd0, FUNC_WWD));
		expected.push_back(v0);
		expected.push_back(v3);
		expected.push_back(v1);
		expected.push_back(v2);
		emit(itype_inst(OP_ADI, 2'd1, 2'd1, imm[7:0]));
		emit(rtype_inst(2'd1, 2'd0, 2'd0, FUNC_WWD));
		expected.push_back(v1 + sign_extend(imm[7:0]));
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_HLT));
		run_program("forwarding_test", program_words.size());
	endtask

	task automatic load_store_test();
		word_t base, v;
		random_word(6, base);
		random_word(16, v);
		// Data area well above the program
		base = base | 16'h0200;
		put_const(2'd0, base);
		put_const(2'd1, v);
		emit(itype_inst(OP_SWD, 2'd0, 2'd1, 8'd4));
		emit(itype_inst(OP_LWD, 2'd0, 2'd2, 8'd4));
		emit(rtype_inst(2'd2, 2'd1, 2'd3, FUNC_ADD));
		emit(rtype_inst(2'd3, 2'd0, 2'd0, FUNC_WWD));
		emit(rtype_inst(2'd2, 2'd0, 2'd0, FUNC_WWD));
		expected.push_back(v + v);
		expected.push_back(v);
		emit(itype_inst(OP_SWD, 2'd0, 2'd3, 8'hFD));
		emit(itype_inst(OP_LWD, 2'd0, 2'd0, 8'hFD));
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_WWD));
		expected.push_back(v + v);
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_HLT));
		run_program("load_store_test", program_words.size());
	endtask

	task automatic branch_test();
		opcode_t br_op [8] = '{OP_BNE, OP_BNE, OP_BEQ, OP_BEQ, OP_BGZ, OP_BGZ, OP_BLZ, OP_BLZ};
		reg_idx_t br_rs [8] = '{2'd0, 2'd0, 2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd2};
		reg_idx_t br_rt [8] = '{2'd2, 2'd1, 2'd2, 2'd2, 2'd0, 2'd0, 2'd0, 2'd0};
		word_t regv [4];
		word_t p, n, m;
		int executed;
		logic taken;
		random_word(16, p);
		random_word(16, n);
		random_word(8, m);
		p = {1'b0, p[14:1], 1'b1};
		n = {1'b1, n[14:0]};
		put_const(2'd0, p);
		put_const(2'd1, n);
		emit(itype_inst(OP_ADI, 2'd0, 2'd2, 8'd0));
		emit(itype_inst(OP_LHI, 2'd0, 2'd3, m[7:0]));
		regv = '{p, n, p, {m[7:0], 8'h00}};
		executed = 6;
		// Taken branches skip a WWD of r3 and its increment
		foreach (br_op[i]) begin
			emit(itype_inst(br_op[i], br_rs[i], br_rt[i], 8'd2));
			emit(rtype_inst(2'd3, 2'd0, 2'd0, FUNC_WWD));
			emit(itype_inst(OP_ADI, 2'd3, 2'd3, 8'd1));
			taken = branch_taken(br_op[i], regv[br_rs[i]], regv[br_rt[i]]);
			executed += 1;
			if (!taken) begin
				expected.push_back(regv[3]);
				regv[3] = regv[3] + 1'b1;
				executed += 2;
			end
		end
		emit(rtype_inst(2'd3, 2'd0, 2'd0, FUNC_WWD));
		expected.push_back(regv[3]);
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_HLT));
		executed += 2;
		run_program("branch_test", executed);
	endtask

	task automatic jump_test();
		int jal_at;
		int jrl_at;
		jal_at = 3;
		jrl_at = 11;
		emit(jtype_inst(OP_JMP, 12'd3));
		emit(rtype_inst(2'd1, 2'd0, 2'd0, FUNC_WWD));
		emit(rtype_inst(2'd1, 2'd0, 2'd0, FUNC_WWD));
		emit(jtype_inst(OP_JAL, 12'd6));
		// Return point of the JPR below
		emit(rtype_inst(2'd2, 2'd0, 2'd0, FUNC_WWD));
		emit(jtype_inst(OP_JMP, 12'd9));
		emit(rtype_inst(2'd2, 2'd0, 2'd0, FUNC_WWD));
		emit(rtype_inst(2'd2, 2'd0, 2'd0, FUNC_JPR));
		emit(rtype_inst(2'd1, 2'd0, 2'd0, FUNC_WWD));
		emit(itype_inst(OP_LHI, 2'd0, 2'd0, 8'd0));
		emit(itype_inst(OP_ADI, 2'd0, 2'd0, 8'd13));
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_JRL));
		emit(rtype_inst(2'd1, 2'd0, 2'd0, FUNC_WWD));
		emit(rtype_inst(2'd2, 2'd0, 2'd0, FUNC_WWD));
		emit(rtype_inst(2'd0, 2'd0, 2'd0, FUNC_HLT));
		expected.push_back(word_t'(jal_at + 1));
		expected.push_back(word_t'(jal_at + 1));
		expected.push_back(word_t'(jrl_at + 1));
		// Path 0 3 6 7 4 5 9 10 11 13 14
		run_program("jump_test", 11);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("Timeout: the DUT did not halt within the cycle budget");
	end

	// Stop at the first assertion failure in the cpu
	always @(posedge Clk) begin
		if (uut.u_cpu.u_cpu_assertions.error_count != 0)
			report_failure("An assertion in the cpu failed");
	end

	initial begin
		Clk = 1'b0;
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		lfsr_state = 32'h2e43_b980;

		alu_ops_test();
		forwarding_test();
		load_store_test();
		branch_test();
		jump_test();

		if (uut.u_cpu.u_cpu_assertions.error_count == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("%0d assertion failures in the cpu",
				uut.u_cpu.u_cpu_assertions.error_count);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

//--- tsc_system.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/control_decoder.sv
hdl/forwarding_unit.sv
hdl/register_file.sv
hdl/alu.sv
hdl/cpu.sv
hdl/dual_port_memory.sv
hdl/tsc_system.sv
tb/cpu_assertions.sv
tb/tsc_system_tb.sv
